//--- include/gem_params.svh
`ifndef GEM_PARAMS_SVH
`define GEM_PARAMS_SVH

// ------------------------------
// cluster link format
// ------------------------------
`define GEM_MXCLST      4     // clusters per bunch crossing
`define GEM_CLSTBITS    14    // size + address bits per cluster word

// ------------------------------
// chamber geometry
// ------------------------------
`define GEM_MXFEB       24    // front-end boards per chamber
`define GEM_INVALID_FEB 24    // feb code for vfat 24..31
`define GEM_INVALID_PAD 192   // pad code for vfat 24..31

// ------------------------------
// storage
// ------------------------------
`define GEM_RAM_ADRB    11    // raw hits ram, 2048 bx deep
`define GEM_INJ_ADRB    10    // injector ram, 1024 tbins deep
`define GEM_TBIN_BITS   12    // injector tbin counter width

`endif

//--- design/gem_cluster_pkg.sv
`include "gem_params.svh"

package gem_cluster_pkg;

  // ------------------------------
  // cluster word, two decodes
  // ------------------------------

  // address part of a cluster, natural vfat id on top
  typedef struct packed {
    logic [4:0] vfat;                          // vfat number, 24..31 unmapped
    logic [5:0] strip;                         // pad within the vfat
  } cluster_adr_t;

  // trigger view of the word
  typedef struct packed {
    logic [2:0]   size;                        // cluster size
    cluster_adr_t adr;                         // 11 bit address
  } cluster_fields_t;

  // storage view, each half gets its own parity in the raw ram
  typedef struct packed {
    logic [`GEM_CLSTBITS/2-1:0] upper;         // bits 13:7
    logic [`GEM_CLSTBITS/2-1:0] lower;         // bits 6:0
  } cluster_halves_t;

  typedef union packed {
    cluster_fields_t f;                        // size/vfat/strip
    cluster_halves_t h;                        // upper/lower half
  } cluster_word_t;

  // ------------------------------
  // decoded coordinates
  // ------------------------------
  typedef logic [4:0] feb_t;                   // 0..23, 24 = none
  typedef logic [2:0] roll_t;                  // eta partition 0..7
  typedef logic [7:0] pad_t;                   // pad in roll 0..191, 192 = none
  typedef logic [`GEM_MXFEB-1:0] feb_list_t;   // one bit per feb

endpackage

//--- design/gem_ram_pkg.sv
`include "gem_params.svh"

package gem_ram_pkg;

  // ------------------------------
  // addresses and counters
  // ------------------------------
  typedef logic [`GEM_RAM_ADRB-1:0]  raw_adr_t;   // raw hits ram bx address
  typedef logic [`GEM_INJ_ADRB-1:0]  inj_adr_t;   // injector ram tbin address
  typedef logic [`GEM_TBIN_BITS-1:0] tbin_t;      // playback tbin count

  // ------------------------------
  // ram words
  // ------------------------------

  // injector word, cluster in [13:0], top two bits spare
  typedef logic [15:0] inj_word_t;

  // raw ram half word, odd parity in bit 7, data in [6:0]
  typedef logic [`GEM_CLSTBITS/2:0] half_word_t;

endpackage

//--- design/gem_injector.sv
`timescale 1ns/100ps
`include "gem_params.svh"

module gem_injector
  import gem_cluster_pkg::*, gem_ram_pkg::*;
(
  input  logic          clock,
  input  logic          sm_reset,
  input  cluster_word_t link_cluster [`GEM_MXCLST],  // clusters from the link
  input  inj_adr_t      inj_rwadr,                   // write tbin address
  input  logic [1:0]    inj_sel,                     // which cluster ram to write
  input  inj_word_t     inj_wdata,                   // write data
  input  logic          inj_wen,                     // write strobe, level
  input  logic          inj_go_gem,                  // start playback
  input  tbin_t         inj_last_tbin,               // last tbin to play
  output cluster_word_t cluster [`GEM_MXCLST]        // link or injected clusters
);

  localparam logic st_pass      = 1'b0;              // link data passes through
  localparam logic st_injecting = 1'b1;              // playing ram contents

  logic     inj_wen_ff;                              // strobe delayed one bx
  logic     wen_os;                                  // one-bx write pulse
  logic     inj_sm;                                  // playback state
  tbin_t    inj_tbin_cnt;                            // tbin being read
  logic     inj_tbin_cnt_done;                       // last tbin reached
  inj_adr_t inj_tbin_adr;                            // ram read address
  logic     pass_ff;                                 // 1 = link selected

  // ------------------------------
  // write strobe one-shot
  // ------------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      inj_wen_ff <= 1'b0;
    end else begin
      inj_wen_ff <= inj_wen;
    end
  end

  assign wen_os = inj_wen & ~inj_wen_ff;             // rising edge only

  // ------------------------------
  // playback state machine
  // ------------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      inj_sm <= st_pass;
    end else begin
      case (inj_sm)
        st_pass:      if (inj_go_gem) inj_sm <= st_injecting;
        st_injecting: if (inj_tbin_cnt_done) inj_sm <= st_pass;
        default:      inj_sm <= st_pass;
      endcase
    end
  end

  // tbin counter sits at 0 in pass, so tbin 0 is read on the first injecting bx
  always_ff @(posedge clock) begin
    if (sm_reset || inj_sm == st_pass) begin
      inj_tbin_cnt <= '0;
    end else begin
      inj_tbin_cnt <= inj_tbin_cnt + 1'b1;
    end
  end

  assign inj_tbin_cnt_done = (inj_tbin_cnt == inj_last_tbin);
  assign inj_tbin_adr      = inj_tbin_cnt[`GEM_INJ_ADRB-1:0];

  // select follows the state one bx late, lining up with the ram read
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      pass_ff <= 1'b1;
    end else begin
      pass_ff <= (inj_sm == st_pass);
    end
  end

  // ------------------------------
  // injector rams, one per cluster
  // ------------------------------
  for (genvar i = 0; i < `GEM_MXCLST; i++) begin : g_inj_ram
    inj_word_t ram [1 << `GEM_INJ_ADRB];             // 1024 x 16
    inj_word_t rdata;                                // registered playback word

    always_ff @(posedge clock) begin
      if (wen_os && inj_sel == 2'(i)) begin
        ram[inj_rwadr] <= inj_wdata;                 // write port
      end
      rdata <= ram[inj_tbin_adr];                    // playback port
    end

    assign cluster[i] = pass_ff ? link_cluster[i]
                                : cluster_word_t'(rdata[`GEM_CLSTBITS-1:0]);
  end

endmodule

//--- design/gem_cluster_decode.sv
`timescale 1ns/100ps
`include "gem_params.svh"

module gem_cluster_decode
  import gem_cluster_pkg::*;
(
  input  logic                   clock,
  input  logic                   sm_reset,
  input  cluster_word_t          cluster [`GEM_MXCLST],       // clusters this bx
  output feb_t                   cluster_feb [`GEM_MXCLST],   // front-end board
  output roll_t                  cluster_roll [`GEM_MXCLST],  // eta partition
  output pad_t                   cluster_pad [`GEM_MXCLST],   // pad in the roll
  output logic [`GEM_MXCLST-1:0] vpf,                         // valid flags
  output feb_list_t              active_feb_list              // febs hit last bx
);

  feb_list_t feb_list_next;                                   // or of this bx

  // ------------------------------
  // vfat to feb/roll/pad map
  // ------------------------------
  // three vfats across each roll, eight rolls, feb numbered column-major
  for (genvar i = 0; i < `GEM_MXCLST; i++) begin : g_map
    roll_t      vfat_row;                                     // v / 3
    logic [1:0] vfat_col;                                     // v mod 3

    // address 11xxxxxxxxx marks an empty slot, same as vfat 24..31
    assign vpf[i] = ~(cluster[i].f.adr.vfat[4:3] == 2'b11);

    assign vfat_row = 3'(cluster[i].f.adr.vfat / 5'd3);       // only used for v < 24
    assign vfat_col = 2'(cluster[i].f.adr.vfat % 5'd3);

    assign cluster_roll[i] = vpf[i] ? vfat_row : '0;
    assign cluster_feb[i]  = vpf[i] ? {vfat_col, vfat_row}    // row + 8 * col
                                    : feb_t'(`GEM_INVALID_FEB);
    assign cluster_pad[i]  = vpf[i] ? {vfat_col, cluster[i].f.adr.strip}  // 64 * col + strip
                                    : pad_t'(`GEM_INVALID_PAD);
  end

  // ------------------------------
  // active feb list
  // ------------------------------
  always_comb begin
    feb_list_next = '0;
    for (int i = 0; i < `GEM_MXCLST; i++) begin
      if (vpf[i]) begin
        feb_list_next[cluster_feb[i]] = 1'b1;                 // feb < 24 when valid
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sm_reset) begin
      active_feb_list <= '0;
    end else begin
      active_feb_list <= feb_list_next;                       // one bx after the clusters
    end
  end

endmodule

//--- design/gem_rawhits_ram.sv
`timescale 1ns/100ps
`include "gem_params.svh"

module gem_rawhits_ram
  import gem_cluster_pkg::*, gem_ram_pkg::*;
(
  input  logic                   clock,
  input  cluster_word_t          cluster [`GEM_MXCLST],  // clusters to store
  input  logic                   fifo_wen,               // 1 = write this bx
  input  raw_adr_t               fifo_wadr,              // write bx address
  input  raw_adr_t               fifo_radr,              // read bx address
  input  logic [1:0]             fifo_sel,               // cluster on the read port
  output cluster_word_t          fifo_rdata,             // selected stored cluster
  output logic [`GEM_MXCLST-1:0] parity_err_gem          // per cluster parity error
);

  cluster_word_t rdata_clst [`GEM_MXCLST];               // read words, all clusters

  // ------------------------------
  // split-half rams per cluster
  // ------------------------------
  // each cluster word is kept as two 2048 x 8 halves, 7 data + odd parity
  for (genvar i = 0; i < `GEM_MXCLST; i++) begin : g_clst
    half_word_t wr_half [2];                             // 0 lower, 1 upper

    assign wr_half[0] = {~^cluster[i].h.lower, cluster[i].h.lower};
    assign wr_half[1] = {~^cluster[i].h.upper, cluster[i].h.upper};

    for (genvar j = 0; j < 2; j++) begin : g_half
      half_word_t ram [1 << `GEM_RAM_ADRB];              // 2048 x 8
      half_word_t rd;                                    // synchronous read
      logic       err;                                   // stored vs recomputed parity

      always_ff @(posedge clock) begin
        if (fifo_wen) begin
          ram[fifo_wadr] <= wr_half[j];
        end
        rd <= ram[fifo_radr];
      end

      assign err = rd[`GEM_CLSTBITS/2] ^ ~^rd[`GEM_CLSTBITS/2-1:0];
    end

    // rebuild the word from its halves
    assign rdata_clst[i] = cluster_word_t'({g_half[1].rd[`GEM_CLSTBITS/2-1:0],
                                            g_half[0].rd[`GEM_CLSTBITS/2-1:0]});

    assign parity_err_gem[i] = g_half[0].err | g_half[1].err;  // either half bad
  end

  // ------------------------------
  // read multiplexer
  // ------------------------------
  assign fifo_rdata = rdata_clst[fifo_sel];

endmodule

//--- design/gem_cluster_top.sv
`timescale 1ns/100ps
`include "gem_params.svh"

module gem_cluster_top
  import gem_cluster_pkg::*, gem_ram_pkg::*;
(
  input  logic                   clock,
  input  logic                   sm_reset,
  input  cluster_word_t          link_cluster [`GEM_MXCLST],  // link clusters
  // injector write and playback
  input  inj_adr_t               inj_rwadr,
  input  logic [1:0]             inj_sel,
  input  inj_word_t              inj_wdata,
  input  logic                   inj_wen,
  input  logic                   inj_go_gem,
  input  tbin_t                  inj_last_tbin,
  // raw hits ram
  input  logic                   fifo_wen,
  input  raw_adr_t               fifo_wadr,
  input  raw_adr_t               fifo_radr,
  input  logic [1:0]             fifo_sel,
  output cluster_word_t          fifo_rdata,
  output logic [`GEM_MXCLST-1:0] parity_err_gem,
  // trigger path
  output cluster_word_t          cluster [`GEM_MXCLST],
  output feb_t                   cluster_feb [`GEM_MXCLST],
  output roll_t                  cluster_roll [`GEM_MXCLST],
  output pad_t                   cluster_pad [`GEM_MXCLST],
  output logic [`GEM_MXCLST-1:0] vpf,
  output feb_list_t              active_feb_list
);

  // ------------------------------
  // source select, link or ram
  // ------------------------------
  gem_injector u_injector (
    .clock         (clock),
    .sm_reset      (sm_reset),
    .link_cluster  (link_cluster),
    .inj_rwadr     (inj_rwadr),
    .inj_sel       (inj_sel),
    .inj_wdata     (inj_wdata),
    .inj_wen       (inj_wen),
    .inj_go_gem    (inj_go_gem),
    .inj_last_tbin (inj_last_tbin),
    .cluster       (cluster)                   // also feeds decode and raw ram
  );

  // ------------------------------
  // trigger decode
  // ------------------------------
  gem_cluster_decode u_decode (
    .clock           (clock),
    .sm_reset        (sm_reset),
    .cluster         (cluster),
    .cluster_feb     (cluster_feb),
    .cluster_roll    (cluster_roll),
    .cluster_pad     (cluster_pad),
    .vpf             (vpf),
    .active_feb_list (active_feb_list)
  );

  // ------------------------------
  // raw hits storage
  // ------------------------------
  gem_rawhits_ram u_rawhits (
    .clock          (clock),
    .cluster        (cluster),
    .fifo_wen       (fifo_wen),
    .fifo_wadr      (fifo_wadr),
    .fifo_radr      (fifo_radr),
    .fifo_sel       (fifo_sel),
    .fifo_rdata     (fifo_rdata),
    .parity_err_gem (parity_err_gem)
  );

endmodule

//--- testbench/tb_gem_cluster.sv
`timescale 1ns/100ps
`include "gem_params.svh"

module tb_gem_cluster
  import gem_cluster_pkg::*, gem_ram_pkg::*;
();

  localparam int period    = 40;                    // ns per bx
  localparam int n_map     = 500;                   // random words for the map test
  localparam int n_feb     = 200;                   // random sets for the feb list test
  localparam int n_raw     = 64;                    // raw ram writes
  localparam int max_tbin  = 63;                    // largest random last tbin
  localparam int max_cycles = 4 + n_map + n_feb + 1 + n_raw * 5
                            + 16 * (max_tbin + 1) + max_tbin + 8 + 200;  // 200 margin

  logic          clock;
  logic          sm_reset;
  cluster_word_t link_cluster [`GEM_MXCLST];
  inj_adr_t      inj_rwadr;
  logic [1:0]    inj_sel;
  inj_word_t     inj_wdata;
  logic          inj_wen;
  logic          inj_go_gem;
  tbin_t         inj_last_tbin;
  logic          fifo_wen;
  raw_adr_t      fifo_wadr;
  raw_adr_t      fifo_radr;
  logic [1:0]    fifo_sel;
  cluster_word_t fifo_rdata;
  logic [3:0]    parity_err_gem;
  cluster_word_t cluster [`GEM_MXCLST];
  feb_t          cluster_feb [`GEM_MXCLST];
  roll_t         cluster_roll [`GEM_MXCLST];
  pad_t          cluster_pad [`GEM_MXCLST];
  logic [3:0]    vpf;
  feb_list_t     active_feb_list;

  int            errors = 0;
  int            checks = 0;
  cluster_word_t raw_model [`GEM_MXCLST][1 << `GEM_RAM_ADRB];  // model of the raw ram
  inj_word_t     inj_model [`GEM_MXCLST][1 << `GEM_INJ_ADRB];  // model of the injector rams
  raw_adr_t      raw_adrs [$];                                  // addresses written

  gem_cluster_top i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // ------------------------------
  // reference model and checks
  // ------------------------------
  task automatic map_expect(input cluster_word_t w, output feb_t f, output roll_t r,
                            output pad_t p, output logic v);
    int vfat;
    int col;
    vfat = int'(w[10:6]);                           // address bits 10:6
    v    = (w[10:9] != 2'b11);                      // top two address bits
    if (vfat < `GEM_MXFEB) begin
      col = vfat % 3;
      r   = roll_t'(vfat / 3);
      f   = feb_t'(vfat / 3 + 8 * col);
      p   = pad_t'(64 * col + int'(w[5:0]));
    end else begin
      r = '0;
      f = feb_t'(`GEM_INVALID_FEB);
      p = pad_t'(`GEM_INVALID_PAD);
    end
  endtask

  task automatic check_cluster(input string what, input cluster_word_t got,
                               input cluster_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_map(input int idx, input feb_t f, input roll_t r, input pad_t p,
                           input logic v, input feb_t ef, input roll_t er, input pad_t ep,
                           input logic ev);
    checks++;
    if (f !== ef || r !== er || p !== ep || v !== ev) begin
      errors++;
      $display("Mismatch at %0t: cluster %0d feb/roll/pad/vpf %0d/%0d/%0d/%b expected %0d/%0d/%0d/%b",
               $time, idx, f, r, p, v, ef, er, ep, ev);
    end
  endtask

  task automatic check_feb_list(input feb_list_t got, input feb_list_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: active feb list %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_parity(input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: parity error flags %b expected %b", $time, got, exp);
    end
  endtask

  task automatic randomize_link();
    for (int i = 0; i < `GEM_MXCLST; i++) begin
      link_cluster[i] = cluster_word_t'(14'($urandom));  // covers vfat 24..31 too
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %-10s %s, %0d errors", name,
             (errors == err_before) ? "ok" : "failed", errors - err_before);
  endtask

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    #(max_cycles * period);
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    int        err0;
    int        last;
    feb_t      ef;
    roll_t     er;
    pad_t      ep;
    logic      ev;
    feb_list_t exp_list;
    void'($urandom(32'h83186e8c));                  // seeds the run once
    sm_reset      = 1'b1;
    inj_rwadr     = '0;
    inj_sel       = '0;
    inj_wdata     = '0;
    inj_wen       = 1'b0;
    inj_go_gem    = 1'b0;
    inj_last_tbin = '0;
    fifo_wen      = 1'b0;
    fifo_wadr     = '0;
    fifo_radr     = '0;
    fifo_sel      = '0;
    for (int i = 0; i < `GEM_MXCLST; i++) link_cluster[i] = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    sm_reset = 1'b0;

    // reset state, link passes through
    err0 = errors;
    check_feb_list(active_feb_list, '0);
    randomize_link();
    #1;
    for (int i = 0; i < `GEM_MXCLST; i++) check_cluster("reset pass", cluster[i], link_cluster[i]);
    report_test("reset", err0);

    // vfat map on random link words
    err0 = errors;
    for (int n = 0; n < n_map; n++) begin
      @(negedge clock);
      randomize_link();
      #1;
      for (int i = 0; i < `GEM_MXCLST; i++) begin
        map_expect(link_cluster[i], ef, er, ep, ev);
        check_cluster("map pass", cluster[i], link_cluster[i]);
        check_map(i, cluster_feb[i], cluster_roll[i], cluster_pad[i], vpf[i], ef, er, ep, ev);
      end
    end
    report_test("mapping", err0);

    // active feb list, checked one bx after each set
    err0 = errors;
    for (int n = 0; n <= n_feb; n++) begin
      @(negedge clock);
      if (n > 0) check_feb_list(active_feb_list, exp_list);
      randomize_link();
      exp_list = '0;
      for (int i = 0; i < `GEM_MXCLST; i++) begin
        map_expect(link_cluster[i], ef, er, ep, ev);
        if (ev) exp_list[ef] = 1'b1;
      end
    end
    report_test("feb list", err0);

    // raw ram write then read back every cluster
    err0 = errors;
    for (int n = 0; n < n_raw; n++) begin
      @(negedge clock);
      randomize_link();
      fifo_wen  = 1'b1;
      fifo_wadr = raw_adr_t'($urandom);
      raw_adrs.push_back(fifo_wadr);
      for (int i = 0; i < `GEM_MXCLST; i++) raw_model[i][fifo_wadr] = link_cluster[i];
    end
    @(negedge clock);
    fifo_wen = 1'b0;
    foreach (raw_adrs[n]) begin
      for (int s = 0; s < `GEM_MXCLST; s++) begin
        fifo_radr = raw_adrs[n];
        fifo_sel  = 2'(s);
        @(negedge clock);                           // registered read has landed
        check_parity(parity_err_gem, 4'b0000);
        check_cluster("raw read", fifo_rdata, raw_model[s][raw_adrs[n]]);
      end
    end
    report_test("raw ram", err0);

    // injector load with a long write strobe, then playback
    err0 = errors;
    last = $urandom_range(max_tbin);
    for (int r = 0; r < `GEM_MXCLST; r++) begin
      for (int k = 0; k <= last; k++) begin
        @(negedge clock);
        inj_sel      = 2'(r);
        inj_rwadr    = inj_adr_t'(k);
        inj_wdata    = 16'($urandom);
        inj_wen      = 1'b1;
        inj_model[r][k] = inj_wdata;                // only the first value counts
        repeat (2) begin
          @(negedge clock);
          inj_wdata = 16'($urandom);
        end
        @(negedge clock);
        inj_wen = 1'b0;
      end
    end
    @(negedge clock);
    inj_last_tbin = tbin_t'(last);
    inj_go_gem    = 1'b1;                           // sampled at e0
    randomize_link();
    @(negedge clock);
    inj_go_gem = 1'b0;
    for (int k = 0; k <= last; k++) begin
      @(negedge clock);                             // after e(k+1)
      randomize_link();
      #1;
      for (int i = 0; i < `GEM_MXCLST; i++) begin
        check_cluster("inject", cluster[i], cluster_word_t'(inj_model[i][k][13:0]));
      end
    end
    @(negedge clock);                               // after e(last+2)
    randomize_link();
    #1;
    for (int i = 0; i < `GEM_MXCLST; i++) check_cluster("link back", cluster[i], link_cluster[i]);
    report_test("injection", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
design/gem_cluster_pkg.sv
design/gem_ram_pkg.sv
design/gem_injector.sv
design/gem_cluster_decode.sv
design/gem_rawhits_ram.sv
design/gem_cluster_top.sv
testbench/tb_gem_cluster.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the gem cluster testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_gem_cluster -o sim_gem_cluster
out=$(./obj_dir/sim_gem_cluster)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi
